// ==== Bender.yml ====
package:
  name: md_bus

sources:
  - rtl/md_types_pkg.sv
  - rtl/md_map_pkg.sv
  - rtl/apb_bus_bridge.sv
  - rtl/mbus_ctrl.sv
  - rtl/rom_bank_map.sv
  - rtl/rom_port.sv
  - rtl/work_ram.sv
  - rtl/md_bus_top.sv
  - target: test
    files:
      - verif/tb_md_bus.sv

// ==== compile.f ====
rtl/md_types_pkg.sv
rtl/md_map_pkg.sv
rtl/apb_bus_bridge.sv
rtl/mbus_ctrl.sv
rtl/rom_bank_map.sv
rtl/rom_port.sv
rtl/work_ram.sv
rtl/md_bus_top.sv
verif/tb_md_bus.sv

// ==== rtl/apb_bus_bridge.sv ====
module apb_bus_bridge import md_types_pkg::*; (
	input  logic              MCLK,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0] pwdata,
	input  logic [1:0]        pstrb,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output bus_req_t          req,
	output logic              req_valid,
	input  logic              rsp_done,
	input  logic [DATA_W-1:0] rsp_data
);

	// Transfer in flight toward the controller
	logic busy;
	logic setup;

	// Setup phase of a new transfer
	assign setup = psel && !penable && !busy;

	// --------------------------------------------------
	// Request capture
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (setup) begin
			req.word_addr <= paddr[ADDR_W-1:1];
			req.wdata     <= pwdata;
			req.write     <= pwrite;
			// Reads always fetch the whole word
			req.be        <= pwrite ? pstrb : 2'b11;
		end
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			busy      <= 1'b0;
			req_valid <= 1'b0;
			pready    <= 1'b0;
		end else begin
			req_valid <= setup;
			pready    <= 1'b0;
			if (setup) begin
				busy <= 1'b1;
			end
			if (rsp_done) begin
				busy   <= 1'b0;
				pready <= 1'b1;
			end
		end
	end

	// Read data held for the access phase
	always_ff @(posedge MCLK) begin
		if (rsp_done) begin
			prdata <= rsp_data;
		end
	end

endmodule

// ==== rtl/mbus_ctrl.sv ====
module mbus_ctrl import md_types_pkg::*, md_map_pkg::*; #(
	parameter int unsigned ROM_BYTES = 32'h0040_0000
) (
	input  logic                          MCLK,
	input  logic                          reset,
	input  bus_req_t                      req,
	input  logic                          req_valid,
	output logic                          rsp_done,
	output logic [DATA_W-1:0]             rsp_data,
	output logic                          bank_wr,
	output logic [$clog2(BANK_COUNT)-1:0] bank_idx,
	output logic [BANK_W-1:0]             bank_data,
	output logic [ADDR_W-2:0]             bus_word_addr,
	input  logic [ADDR_W-2:0]             mapped_addr,
	output logic                          rom_start,
	output logic [ADDR_W-2:0]             rom_word_addr,
	input  logic                          rom_done,
	input  logic [DATA_W-1:0]             rom_rdata,
	output logic                          ram_we,
	output logic [1:0]                    ram_be,
	output logic [ADDR_W-2:0]             ram_addr,
	output logic [DATA_W-1:0]             ram_wdata,
	input  logic [DATA_W-1:0]             ram_q,
	output logic                          z80_busreq,
	output logic                          z80_reset_n
);

	mstate_e           state;
	bus_req_t          cur;
	region_e           region;
	logic [ADDR_W-1:0] byte_addr;
	logic [DATA_W-1:0] rdata;
	logic [DATA_W-1:0] open_bus;
	logic              ctrl_bit;
	logic              sel_cycle;

	assign byte_addr = {cur.word_addr, 1'b0};
	assign sel_cycle = (state == SELECT);

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------
	always_comb begin
		if (byte_addr < ROM_WINDOW_END) begin
			// Cartridge window, past the end of the ROM reads 0
			region = (byte_addr < ROM_BYTES) ? ROM : ROM_HOLE;
		end else if (byte_addr[23:21] == RAM_BASE_HI) begin
			region = RAM;
		end else if (byte_addr[23:8] == BANK_PAGE) begin
			region = BANK;
		end else if (byte_addr[23:12] == CTRL_PAGE && byte_addr[7:1] == 7'd0) begin
			if (byte_addr[11:8] == 4'h1) begin
				region = CTRL_BUSREQ;
			end else if (byte_addr[11:8] == 4'h2) begin
				region = CTRL_RESET;
			end else begin
				region = NONE;
			end
		end else begin
			region = NONE;
		end
	end

	// Bus acknowledge reads back as the inverse of the request
	assign ctrl_bit = (region == CTRL_BUSREQ) ? ~z80_busreq : z80_reset_n;

	// Strobes toward the targets
	assign rom_start = sel_cycle && (region == ROM) && !cur.write;
	assign ram_we    = sel_cycle && (region == RAM) && cur.write;
	assign bank_wr   = sel_cycle && (region == BANK) && cur.write;
	assign rsp_done  = (state == FINISH);

	assign bus_word_addr = cur.word_addr;
	assign rom_word_addr = mapped_addr;
	assign bank_idx      = cur.word_addr[$clog2(BANK_COUNT)-1:0];
	assign bank_data     = cur.wdata[BANK_W-1:0];
	assign ram_addr      = cur.word_addr;
	assign ram_be        = cur.be;
	assign ram_wdata     = cur.wdata;
	assign rsp_data      = rdata;

	// --------------------------------------------------
	// Controller FSM and control registers
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= IDLE;
			open_bus    <= OPEN_BUS_INIT;
			z80_busreq  <= 1'b0;
			z80_reset_n <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				if (req_valid) begin
					state <= SELECT;
				end
			end
			SELECT: begin
				state <= FINISH;
				if (region == ROM && !cur.write) begin
					state <= ROM_WAIT;
				end else if (region == RAM && !cur.write) begin
					state <= RAM_READ;
				end
				// Only the upper byte carries the control bit
				if (cur.write && cur.be[1]) begin
					if (region == CTRL_BUSREQ) begin
						z80_busreq <= cur.wdata[8];
					end
					if (region == CTRL_RESET) begin
						z80_reset_n <= cur.wdata[8];
					end
				end
			end
			RAM_READ: begin
				open_bus <= ram_q;
				state    <= FINISH;
			end
			ROM_WAIT: begin
				if (rom_done) begin
					open_bus <= rom_rdata;
					state    <= FINISH;
				end
			end
			default: begin
				state <= IDLE;
			end
			endcase
		end
	end

	// Request and read data registers
	always_ff @(posedge MCLK) begin
		if (state == IDLE && req_valid) begin
			cur <= req;
		end
	end

	always_ff @(posedge MCLK) begin
		if (sel_cycle) begin
			case (region)
			ROM_HOLE:                rdata <= '0;
			CTRL_BUSREQ, CTRL_RESET: rdata <= {open_bus[15:9], ctrl_bit, open_bus[7:0]};
			default:                 rdata <= open_bus;
			endcase
		end else if (state == RAM_READ) begin
			rdata <= ram_q;
		end else if (state == ROM_WAIT && rom_done) begin
			rdata <= rom_rdata;
		end
	end

endmodule

// ==== rtl/md_bus_top.sv ====
module md_bus_top import md_types_pkg::*, md_map_pkg::*; (
	input  logic              MCLK,
	input  logic              reset,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [ADDR_W-1:0] paddr,
	input  logic [DATA_W-1:0] pwdata,
	input  logic [1:0]        pstrb,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output logic [ADDR_W-2:0] rom_addr,
	output logic              rom_req,
	input  logic              rom_ack,
	input  logic [DATA_W-1:0] rom_data,
	output logic              z80_busreq,
	output logic              z80_reset_n
);

	localparam int unsigned ROM_BYTES = 32'h0040_0000;
	localparam int          RAM_AW    = 15;

	bus_req_t                      req;
	logic                          req_valid;
	logic                          rsp_done;
	logic [DATA_W-1:0]             rsp_data;
	logic                          bank_wr;
	logic [$clog2(BANK_COUNT)-1:0] bank_idx;
	logic [BANK_W-1:0]             bank_data;
	logic [ADDR_W-2:0]             bus_word_addr;
	logic [ADDR_W-2:0]             mapped_addr;
	logic                          rom_start;
	logic [ADDR_W-2:0]             rom_word_addr;
	logic                          rom_done;
	logic [DATA_W-1:0]             rom_rdata;
	logic                          ram_we;
	logic [1:0]                    ram_be;
	logic [ADDR_W-2:0]             ram_addr;
	logic [DATA_W-1:0]             ram_wdata;
	logic [DATA_W-1:0]             ram_q;

	apb_bus_bridge u_apb_bus_bridge (
		.MCLK      (MCLK),
		.reset     (reset),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pready    (pready),
		.req       (req),
		.req_valid (req_valid),
		.rsp_done  (rsp_done),
		.rsp_data  (rsp_data)
	);

	mbus_ctrl #(
		.ROM_BYTES (ROM_BYTES)
	) u_mbus_ctrl (
		.MCLK          (MCLK),
		.reset         (reset),
		.req           (req),
		.req_valid     (req_valid),
		.rsp_done      (rsp_done),
		.rsp_data      (rsp_data),
		.bank_wr       (bank_wr),
		.bank_idx      (bank_idx),
		.bank_data     (bank_data),
		.bus_word_addr (bus_word_addr),
		.mapped_addr   (mapped_addr),
		.rom_start     (rom_start),
		.rom_word_addr (rom_word_addr),
		.rom_done      (rom_done),
		.rom_rdata     (rom_rdata),
		.ram_we        (ram_we),
		.ram_be        (ram_be),
		.ram_addr      (ram_addr),
		.ram_wdata     (ram_wdata),
		.ram_q         (ram_q),
		.z80_busreq    (z80_busreq),
		.z80_reset_n   (z80_reset_n)
	);

	rom_bank_map u_rom_bank_map (
		.MCLK          (MCLK),
		.reset         (reset),
		.bank_wr       (bank_wr),
		.bank_idx      (bank_idx),
		.bank_data     (bank_data),
		.bus_word_addr (bus_word_addr),
		.mapped_addr   (mapped_addr)
	);

	rom_port u_rom_port (
		.MCLK          (MCLK),
		.reset         (reset),
		.rom_start     (rom_start),
		.rom_word_addr (rom_word_addr),
		.rom_done      (rom_done),
		.rom_rdata     (rom_rdata),
		.rom_addr      (rom_addr),
		.rom_req       (rom_req),
		.rom_ack       (rom_ack),
		.rom_data      (rom_data)
	);

	work_ram #(
		.RAM_AW (RAM_AW)
	) u_work_ram (
		.MCLK      (MCLK),
		.ram_we    (ram_we),
		.ram_be    (ram_be),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_q     (ram_q)
	);

endmodule

// ==== rtl/md_map_pkg.sv ====
package md_map_pkg;

	// --------------------------------------------------
	// 68000 address map
	// --------------------------------------------------

	// Decoded target of one access
	typedef enum logic [2:0] {
		ROM,
		ROM_HOLE,
		RAM,
		BANK,
		CTRL_BUSREQ,
		CTRL_RESET,
		NONE
	} region_e;

	// Work RAM at E00000-FFFFFF
	localparam logic [2:0] RAM_BASE_HI = 3'b111;

	// Bank registers at A130xx
	localparam logic [15:0] BANK_PAGE = 16'hA130;

	// Sound CPU control at A11xxx
	localparam logic [11:0] CTRL_PAGE = 12'hA11;

	// Cartridge window 000000-9FFFFF
	localparam logic [23:0] ROM_WINDOW_END = 24'hA00000;

	// NOP opcode, value of the open bus after reset
	localparam logic [15:0] OPEN_BUS_INIT = 16'h4E71;

	// 512 KB page mapper
	localparam int BANK_COUNT = 8;
	localparam int BANK_W     = 5;

endpackage

// ==== rtl/md_types_pkg.sv ====
package md_types_pkg;

	// Bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 16;

	// --------------------------------------------------
	// One host transaction as seen by the bus controller
	// --------------------------------------------------
	typedef struct packed {
		// Word address, byte address bit 0 dropped
		logic [ADDR_W-2:0] word_addr;
		logic [DATA_W-1:0] wdata;
		logic              write;
		// Upper lane in bit 1
		logic [1:0]        be;
	} bus_req_t;

	// Main bus controller states
	typedef enum logic [2:0] {
		IDLE,
		SELECT,
		RAM_READ,
		ROM_WAIT,
		FINISH
	} mstate_e;

endpackage

// ==== rtl/rom_bank_map.sv ====
module rom_bank_map import md_types_pkg::*, md_map_pkg::*; (
	input  logic                          MCLK,
	input  logic                          reset,
	input  logic                          bank_wr,
	input  logic [$clog2(BANK_COUNT)-1:0] bank_idx,
	input  logic [BANK_W-1:0]             bank_data,
	input  logic [ADDR_W-2:0]             bus_word_addr,
	output logic [ADDR_W-2:0]             mapped_addr
);

	logic [BANK_W-1:0] bank_reg [BANK_COUNT];
	// Set by the first page write
	logic              bank_on;

	// --------------------------------------------------
	// Page registers
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			bank_on <= 1'b0;
			// Identity mapping
			for (int i = 0; i < BANK_COUNT; i++) begin
				bank_reg[i] <= BANK_W'(i);
			end
		end else if (bank_wr && bank_idx != '0) begin
			// Slot 0 stays fixed on the first page
			bank_reg[bank_idx] <= bank_data;
			bank_on            <= 1'b1;
		end
	end

	// 512 KB slot from byte address bits 21:19, offset from bits 18:1
	always_comb begin
		if (bank_on) begin
			mapped_addr = {bank_reg[bus_word_addr[20:18]], bus_word_addr[17:0]};
		end else begin
			mapped_addr = bus_word_addr;
		end
	end

endmodule

// ==== rtl/rom_port.sv ====
module rom_port import md_types_pkg::*; (
	input  logic              MCLK,
	input  logic              reset,
	input  logic              rom_start,
	input  logic [ADDR_W-2:0] rom_word_addr,
	output logic              rom_done,
	output logic [DATA_W-1:0] rom_rdata,
	output logic [ADDR_W-2:0] rom_addr,
	output logic              rom_req,
	input  logic              rom_ack,
	input  logic [DATA_W-1:0] rom_data
);

	// Waiting for the acknowledge to catch up
	logic busy;
	logic ack_match;

	assign ack_match = busy && (rom_ack == rom_req);

	// --------------------------------------------------
	// Toggle handshake
	// --------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			busy     <= 1'b0;
			rom_req  <= 1'b0;
			rom_done <= 1'b0;
		end else begin
			rom_done <= ack_match;
			if (rom_start) begin
				rom_req <= ~rom_req;
				busy    <= 1'b1;
			end else if (ack_match) begin
				busy <= 1'b0;
			end
		end
	end

	// Address held for the whole access
	always_ff @(posedge MCLK) begin
		if (rom_start) begin
			rom_addr <= rom_word_addr;
		end
		if (ack_match) begin
			rom_rdata <= rom_data;
		end
	end

endmodule

// ==== rtl/work_ram.sv ====
module work_ram import md_types_pkg::*; #(
	parameter int RAM_AW = 15
) (
	input  logic              MCLK,
	input  logic              ram_we,
	input  logic [1:0]        ram_be,
	input  logic [ADDR_W-2:0] ram_addr,
	input  logic [DATA_W-1:0] ram_wdata,
	output logic [DATA_W-1:0] ram_q
);

	// Upper address bits ignored, so the RAM repeats over its window
	logic [RAM_AW-1:0] addr;

	assign addr = ram_addr[RAM_AW-1:0];

	// --------------------------------------------------
	// One byte array per lane
	// --------------------------------------------------
	for (genvar lane = 0; lane < 2; lane++) begin : g_lane
		logic [7:0] mem [2**RAM_AW];

		always_ff @(posedge MCLK) begin
			if (ram_we && ram_be[lane]) begin
				mem[addr] <= ram_wdata[lane*8 +: 8];
			end
			ram_q[lane*8 +: 8] <= mem[addr];
		end
	end

endmodule

// ==== verif/tb_md_bus.sv ====
module tb_md_bus import md_types_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic              MCLK = 1'b0;
	logic              reset;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [1:0]        pstrb;
	logic [DATA_W-1:0] prdata;
	logic              pready;
	logic [ADDR_W-2:0] rom_addr;
	logic              rom_req;
	logic              rom_ack = 1'b0;
	logic [DATA_W-1:0] rom_data = '0;
	logic              z80_busreq;
	logic              z80_reset_n;

	// Shared by stimulus and ROM model
	logic [31:0]       lfsr = 32'h4d89;
	// Expected open bus word
	logic [DATA_W-1:0] last_word = 16'h4E71;
	int                ack_wait = -1;

	md_bus_top u_md_bus_top (
		.MCLK        (MCLK),
		.reset       (reset),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pstrb       (pstrb),
		.prdata      (prdata),
		.pready      (pready),
		.rom_addr    (rom_addr),
		.rom_req     (rom_req),
		.rom_ack     (rom_ack),
		.rom_data    (rom_data),
		.z80_busreq  (z80_busreq),
		.z80_reset_n (z80_reset_n)
	);

	always #5 MCLK = ~MCLK;

	// --------------------------------------------------
	// Random source and reference rules
	// --------------------------------------------------
	function automatic logic lfsr_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic logic [15:0] lfsr_word(input int nbits);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) begin
			v = {v[14:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic logic [15:0] rom_word(input logic [ADDR_W-2:0] waddr);
		return waddr[15:0] ^ 16'hA5C3;
	endfunction

	function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
		input logic [15:0] new_w, input logic [1:0] strb);
		logic [15:0] m;
		m[15:8] = strb[1] ? new_w[15:8] : old_w[15:8];
		m[7:0]  = strb[0] ? new_w[7:0] : old_w[7:0];
		return m;
	endfunction

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		$display("** Error: %s = %h, expected %h", name, got, exp);
		abort_run();
	endtask

	// ROM answers after 0 to 7 cycles
	always @(posedge MCLK) begin
		if (reset) begin
			rom_ack  <= 1'b0;
			ack_wait = -1;
		end else if (rom_req != rom_ack) begin
			if (ack_wait < 0) begin
				ack_wait = int'(lfsr_word(3));
			end
			if (ack_wait == 0) begin
				rom_data <= rom_word(rom_addr);
				rom_ack  <= rom_req;
				ack_wait = -1;
			end else begin
				ack_wait = ack_wait - 1;
			end
		end
	end

	// --------------------------------------------------
	// APB driver
	// --------------------------------------------------
	task automatic wait_ready();
		int cycles = 0;
		@(negedge MCLK);
		while (!pready) begin
			if (cycles >= TIMEOUT) begin
				$display("Timeout: pready did not rise within %0d cycles", TIMEOUT);
				abort_run();
			end
			cycles++;
			@(negedge MCLK);
		end
	endtask

	task automatic apb_transfer(input logic [ADDR_W-1:0] addr, input logic write,
		input logic [DATA_W-1:0] data, input logic [1:0] strb,
		output logic [DATA_W-1:0] rdata);
		@(posedge MCLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= data;
		pstrb   <= strb;
		@(posedge MCLK);
		penable <= 1'b1;
		wait_ready();
		rdata = prdata;
		@(posedge MCLK);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [1:0] strb);
		logic [DATA_W-1:0] unused;
		apb_transfer(addr, 1'b1, data, strb, unused);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		apb_transfer(addr, 1'b0, '0, 2'b00, data);
	endtask

	task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		logic [DATA_W-1:0] d;
		apb_read(addr, d);
		assert (d === exp) else report_mismatch("prdata", d, exp);
	endtask

	task automatic check_rom_read(input logic [ADDR_W-1:0] addr,
		input logic [ADDR_W-2:0] waddr);
		check_read(addr, rom_word(waddr));
		assert (rom_addr === waddr) else report_mismatch("rom_addr", rom_addr, waddr);
		last_word = rom_word(waddr);
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic test_reset_state();
		assert (z80_busreq === 1'b0) else report_mismatch("z80_busreq", z80_busreq, 0);
		assert (z80_reset_n === 1'b0) else report_mismatch("z80_reset_n", z80_reset_n, 0);
		check_read(24'hA11100, 16'h4F71);
		check_read(24'hA11200, 16'h4E71);
	endtask

	task automatic test_work_ram();
		logic [15:0] r;
		logic [15:0] d;
		logic [15:0] exp;
		logic [23:0] base;
		for (int i = 0; i < 4; i++) begin
			r    = lfsr_word(15);
			base = {8'hEA, r[14:0], 1'b0};
			exp  = lfsr_word(16);
			apb_write(base, exp, 2'b11);
			d    = lfsr_word(16);
			apb_write(base, d, 2'b10);
			exp  = merge_bytes(exp, d, 2'b10);
			// Lower byte still from the full write
			check_read(base, exp);
			d    = lfsr_word(16);
			apb_write(base, d, 2'b01);
			exp  = merge_bytes(exp, d, 2'b01);
			check_read(base, exp);
			// Same word through the mirrors
			check_read({8'hE0, base[15:0]}, exp);
			check_read({8'hFF, base[15:0]}, exp);
			last_word = exp;
			// RAM reads feed the open bus
			check_read(24'hA20000, last_word);
		end
	endtask

	task automatic test_rom_reads();
		logic [15:0] hi;
		logic [15:0] lo;
		logic [23:0] addr;
		check_rom_read(24'h000000, 23'h000000);
		check_rom_read(24'h3FFFFE, 23'h1FFFFF);
		for (int i = 0; i < 4; i++) begin
			hi   = lfsr_word(6);
			lo   = lfsr_word(15);
			addr = {2'b00, hi[5:0], lo[14:0], 1'b0};
			check_rom_read(addr, addr[23:1]);
		end
	endtask

	task automatic test_bank_map();
		// Slot 5 to page 9
		apb_write(24'hA1300A, 16'h0009, 2'b11);
		check_rom_read(24'h280246, {5'd9, 18'h00123});
		apb_write(24'hA13000, 16'h0003, 2'b11);
		check_rom_read(24'h000100, 23'h000080);
		check_rom_read(24'h280246, {5'd9, 18'h00123});
		check_rom_read(24'h100004, 23'h080002);
	endtask

	task automatic test_open_bus();
		logic req_before;
		check_rom_read(24'h000100, 23'h000080);
		check_read(24'hA20000, last_word);
		req_before = rom_req;
		check_read(24'h500000, 16'h0000);
		assert (rom_req === req_before) else report_mismatch("rom_req", rom_req, req_before);
	endtask

	task automatic test_ctrl_regs();
		apb_write(24'hA11100, 16'h0100, 2'b11);
		assert (z80_busreq === 1'b1) else report_mismatch("z80_busreq", z80_busreq, 1);
		check_read(24'hA11100, {last_word[15:9], 1'b0, last_word[7:0]});
		apb_write(24'hA11200, 16'h0100, 2'b11);
		assert (z80_reset_n === 1'b1) else report_mismatch("z80_reset_n", z80_reset_n, 1);
		check_read(24'hA11200, {last_word[15:9], 1'b1, last_word[7:0]});
		// Lower byte alone leaves both bits alone
		apb_write(24'hA11100, 16'h0000, 2'b01);
		apb_write(24'hA11200, 16'h0000, 2'b01);
		assert (z80_busreq === 1'b1) else report_mismatch("z80_busreq", z80_busreq, 1);
		assert (z80_reset_n === 1'b1) else report_mismatch("z80_reset_n", z80_reset_n, 1);
		apb_write(24'hA11100, 16'h0000, 2'b11);
		assert (z80_busreq === 1'b0) else report_mismatch("z80_busreq", z80_busreq, 0);
	endtask

	initial begin
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		pstrb   = 2'b00;
		repeat (4) @(posedge MCLK);
		reset <= 1'b0;
		test_reset_state();
		test_work_ram();
		test_rom_reads();
		test_bank_map();
		test_open_bus();
		test_ctrl_regs();
		$display("All tests passed");
		$finish;
	end

endmodule
